/* expu_config.svh */
`ifndef EXPU_CONFIG_SVH
`define EXPU_CONFIG_SVH

// Lanes per vector.
`define EXPU_N_ROWS 4

// Pipeline registers per lane.
`define EXPU_NUM_STAGES 3

// Signed Q8.8 operand format.
`define EXPU_FIX_WIDTH 16
`define EXPU_FIX_FRAC 8

// Integer part of the scaled product.
`define EXPU_INT_WIDTH 9

// log2(e) in Q2.10, unsigned.
`define EXPU_LOG2E_WIDTH 12
`define EXPU_LOG2E_FRAC 10
`define EXPU_LOG2E_Q10 12'd1477

`endif

/* expu_pkg.sv */
`include "expu_config.svh"

package expu_pkg;

    // Brain float 16.
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [6:0] mantissa;
    } bf16_t;

    // Operand class decided at decode and carried to the result stage.
    typedef enum logic [2:0] {
        NORMAL,
        SAT_POS,
        SAT_NEG,
        POS_INF,
        NEG_INF,
        NAN
    } expu_class_e;

    // Decode to execute.
    typedef struct packed {
        expu_class_e                        cls;
        logic signed [`EXPU_FIX_WIDTH-1:0]  x;
    } expu_dec_t;

    // Execute to result.
    typedef struct packed {
        expu_class_e                        cls;
        logic signed [`EXPU_INT_WIDTH-1:0]  int_part;
        logic [`EXPU_FIX_FRAC-1:0]          frac;
    } expu_exe_t;

    // Request identifier.
    typedef logic [7:0] expu_tag_t;

endpackage

/* expu_decode.sv */
`timescale 1ns/1ps
`include "expu_config.svh"

module expu_decode (
    input  expu_pkg::bf16_t     op_i,
    output expu_pkg::expu_dec_t dec_o
);

    import expu_pkg::*;

    // Exponent at which the significand lands unshifted in Q8.8.
    localparam int unsigned BIAS_SHIFT = 127 + 7 - `EXPU_FIX_FRAC;
    // First exponent whose magnitude no longer fits the signed format.
    localparam int unsigned SAT_EXP    = 127 + `EXPU_FIX_WIDTH - 1 - `EXPU_FIX_FRAC;

    logic [`EXPU_FIX_WIDTH-1:0] sig;
    logic [`EXPU_FIX_WIDTH-1:0] mag;

    assign sig = {{(`EXPU_FIX_WIDTH - 8){1'b0}}, 1'b1, op_i.mantissa};

    // Variable shift into fixed point, truncating toward zero.
    always_comb begin
        if (op_i.exponent >= 8'(BIAS_SHIFT)) begin
            mag = sig << (op_i.exponent - 8'(BIAS_SHIFT));
        end else begin
            mag = sig >> (8'(BIAS_SHIFT) - op_i.exponent);
        end
    end

    always_comb begin
        dec_o.cls = NORMAL;
        dec_o.x   = '0;
        if (op_i.exponent == 8'hff) begin
            if (op_i.mantissa != '0) begin
                dec_o.cls = NAN;
            end else if (op_i.sign) begin
                dec_o.cls = NEG_INF;
            end else begin
                dec_o.cls = POS_INF;
            end
        end else if (op_i.exponent >= 8'(SAT_EXP)) begin
            dec_o.cls = op_i.sign ? SAT_NEG : SAT_POS;
        end else if (op_i.exponent != 8'h00) begin
            // Zero and denormals keep x at 0.
            dec_o.x = op_i.sign ? -mag : mag;
        end
    end

endmodule

/* expu_execute.sv */
`timescale 1ns/1ps
`include "expu_config.svh"

module expu_execute (
    input  expu_pkg::expu_dec_t dec_i,
    output expu_pkg::expu_exe_t exe_o
);

    import expu_pkg::*;

    localparam int unsigned PROD_WIDTH = `EXPU_FIX_WIDTH + `EXPU_LOG2E_WIDTH + 1;
    localparam int unsigned T_WIDTH    = PROD_WIDTH - `EXPU_LOG2E_FRAC;

    logic signed [`EXPU_LOG2E_WIDTH:0] log2e;
    logic signed [PROD_WIDTH-1:0]      prod;
    logic signed [PROD_WIDTH-1:0]      prod_scaled;
    logic signed [T_WIDTH-1:0]         t;

    // Zero-extended so the product stays signed.
    assign log2e = $signed({1'b0, `EXPU_LOG2E_Q10});

    assign prod = dec_i.x * log2e;

    // Back to Q8.8; arithmetic shift floors.
    assign prod_scaled = prod >>> `EXPU_LOG2E_FRAC;
    assign t           = prod_scaled[T_WIDTH-1:0];

    // |t| stays below 2^16, so the upper bits are plain sign copies.
    always_comb begin
        exe_o.cls      = dec_i.cls;
        exe_o.int_part = t[`EXPU_FIX_FRAC +: `EXPU_INT_WIDTH];
        exe_o.frac     = t[`EXPU_FIX_FRAC-1:0];
    end

endmodule

/* expu_result.sv */
`timescale 1ns/1ps

module expu_result (
    input  expu_pkg::expu_exe_t exe_i,
    output expu_pkg::bf16_t     res_o
);

    import expu_pkg::*;

    localparam bf16_t RES_QNAN = '{sign: 1'b0, exponent: 8'hff, mantissa: 7'h40};
    localparam bf16_t RES_INF  = '{sign: 1'b0, exponent: 8'hff, mantissa: 7'h00};
    localparam bf16_t RES_ZERO = '{sign: 1'b0, exponent: 8'h00, mantissa: 7'h00};

    logic signed [9:0] exp_biased;
    logic              underflow;
    logic              overflow;

    assign exp_biased = $signed({exe_i.int_part[8], exe_i.int_part}) + 10'sd127;

    // No denormal outputs.
    assign underflow  = exp_biased <= 10'sd0;
    assign overflow   = exp_biased >= 10'sd255;

    always_comb begin
        unique case (exe_i.cls)
            NAN: begin
                res_o = RES_QNAN;
            end
            POS_INF, SAT_POS: begin
                res_o = RES_INF;
            end
            NEG_INF, SAT_NEG: begin
                res_o = RES_ZERO;
            end
            default: begin
                if (underflow) begin
                    res_o = RES_ZERO;
                end else if (overflow) begin
                    res_o = RES_INF;
                end else begin
                    // Fraction used directly as mantissa, truncated.
                    res_o.sign     = 1'b0;
                    res_o.exponent = exp_biased[7:0];
                    res_o.mantissa = exe_i.frac[7:1];
                end
            end
        endcase
    end

endmodule

/* expu_row.sv */
`timescale 1ns/1ps
`include "expu_config.svh"

module expu_row (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        clear_i,
    input  logic [`EXPU_NUM_STAGES-1:0] stage_en_i,
    input  expu_pkg::bf16_t             op_i,
    output expu_pkg::bf16_t             res_o
);

    import expu_pkg::*;

    expu_dec_t dec_d;
    expu_dec_t dec_q;
    expu_exe_t exe_d;
    expu_exe_t exe_q;
    bf16_t     res_d;
    bf16_t     res_q;

    expu_decode i_decode (
        .op_i  (op_i),
        .dec_o (dec_d)
    );

    expu_execute i_execute (
        .dec_i (dec_q),
        .exe_o (exe_d)
    );

    expu_result i_result (
        .exe_i (exe_q),
        .res_o (res_d)
    );

    // One register per stage, each loaded by its own enable.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dec_q <= '0;
            exe_q <= '0;
            res_q <= '0;
        end else if (clear_i) begin
            dec_q <= '0;
            exe_q <= '0;
            res_q <= '0;
        end else begin
            if (stage_en_i[0]) begin
                dec_q <= dec_d;
            end
            if (stage_en_i[1]) begin
                exe_q <= exe_d;
            end
            if (stage_en_i[2]) begin
                res_q <= res_d;
            end
        end
    end

    assign res_o = res_q;

endmodule

/* expu_pipe_ctrl.sv */
`timescale 1ns/1ps
`include "expu_config.svh"

module expu_pipe_ctrl #(
    parameter int unsigned N_ROWS   = 1,
    parameter type         TAG_TYPE = expu_pkg::expu_tag_t
) (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  logic                                       clear_i,
    input  logic                                       enable_i,
    input  logic                                       valid_i,
    input  logic                                       ready_i,
    input  logic [N_ROWS-1:0]                          strb_i,
    input  TAG_TYPE                                    tag_i,
    output logic                                       valid_o,
    output logic                                       ready_o,
    output logic [N_ROWS-1:0]                          strb_o,
    output TAG_TYPE                                    tag_o,
    output logic                                       busy_o,
    output logic [N_ROWS-1:0][`EXPU_NUM_STAGES-1:0]    stage_en_o
);

    localparam int unsigned NS = `EXPU_NUM_STAGES;

    typedef struct packed {
        logic              valid;
        logic [N_ROWS-1:0] strb;
        TAG_TYPE           tag;
    } slot_t;

    // Slot 0 is the input port, slots 1..NS are the registers.
    slot_t [NS:0]   slot;
    slot_t [NS-1:0] slot_q;
    logic  [NS-1:0] move;
    logic  [NS-1:0] occupied;

    assign slot[0]    = '{valid: valid_i, strb: strb_i, tag: tag_i};
    assign slot[NS:1] = slot_q;

    // Register j loads when it is empty or drains itself.
    always_comb begin
        move[NS-1] = ready_i | ~slot_q[NS-1].valid;
        for (int j = NS - 2; j >= 0; j--) begin
            move[j] = move[j+1] | ~slot_q[j].valid;
        end
    end

    // Only strobed lanes of valid items clock their datapath.
    always_comb begin
        for (int r = 0; r < N_ROWS; r++) begin
            for (int j = 0; j < NS; j++) begin
                stage_en_o[r][j] = enable_i & move[j] & slot[j].valid & slot[j].strb[r];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            slot_q <= '0;
        end else if (clear_i) begin
            slot_q <= '0;
        end else if (enable_i) begin
            for (int j = 0; j < NS; j++) begin
                if (move[j]) begin
                    slot_q[j] <= slot[j];
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < NS; j++) begin
            occupied[j] = slot_q[j].valid;
        end
    end

    assign valid_o = slot[NS].valid;
    assign strb_o  = slot[NS].strb;
    assign tag_o   = slot[NS].tag;
    assign ready_o = enable_i & move[0];
    assign busy_o  = |occupied;

endmodule

/* expu_top.sv */
`timescale 1ns/1ps
`include "expu_config.svh"

module expu_top (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    clear_i,
    input  logic                                    enable_i,
    input  logic                                    valid_i,
    input  logic                                    ready_i,
    input  logic [`EXPU_N_ROWS-1:0]                 strb_i,
    input  expu_pkg::bf16_t [`EXPU_N_ROWS-1:0]      op_i,
    input  expu_pkg::expu_tag_t                     tag_i,
    output logic                                    valid_o,
    output logic                                    ready_o,
    output logic [`EXPU_N_ROWS-1:0]                 strb_o,
    output expu_pkg::expu_tag_t                     tag_o,
    output expu_pkg::bf16_t [`EXPU_N_ROWS-1:0]      res_o,
    output logic                                    busy_o
);

    logic [`EXPU_N_ROWS-1:0][`EXPU_NUM_STAGES-1:0] stage_en;

    expu_pipe_ctrl #(
        .N_ROWS   (`EXPU_N_ROWS),
        .TAG_TYPE (expu_pkg::expu_tag_t)
    ) i_pipe_ctrl (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (clear_i),
        .enable_i   (enable_i),
        .valid_i    (valid_i),
        .ready_i    (ready_i),
        .strb_i     (strb_i),
        .tag_i      (tag_i),
        .valid_o    (valid_o),
        .ready_o    (ready_o),
        .strb_o     (strb_o),
        .tag_o      (tag_o),
        .busy_o     (busy_o),
        .stage_en_o (stage_en)
    );

    // One datapath per lane.
    for (genvar r = 0; r < `EXPU_N_ROWS; r++) begin : gen_rows
        expu_row i_row (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .clear_i    (clear_i),
            .stage_en_i (stage_en[r]),
            .op_i       (op_i[r]),
            .res_o      (res_o[r])
        );
    end

endmodule

/* expu_sva.sv */
`timescale 1ns/1ps
`include "expu_config.svh"

module expu_sva (
    input logic                               clk_i,
    input logic                               rst_ni,
    input logic                               clear_i,
    input logic                               enable_i,
    input logic                               ready_i,
    input logic                               valid_o,
    input logic                               ready_o,
    input logic [`EXPU_N_ROWS-1:0]            strb_o,
    input expu_pkg::expu_tag_t                tag_o,
    input expu_pkg::bf16_t [`EXPU_N_ROWS-1:0] res_o
);

    // Nothing valid while in reset.
    a_reset_empty: assert property (@(posedge clk_i) !rst_ni |-> !valid_o)
        else $error("valid_o high during reset");

    // Stalled output holds.
    a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i && !clear_i |=>
            valid_o && $stable(tag_o) && $stable(strb_o) && $stable(res_o))
        else $error("output changed while stalled");

    a_disabled_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !enable_i |-> !ready_o)
        else $error("ready_o high while disabled");

endmodule

bind expu_top expu_sva i_sva (.*);

/* tb_expu_top.sv */
`timescale 1ns/1ps
`include "expu_config.svh"

module tb_expu_top;

    import expu_pkg::*;

    localparam int N = `EXPU_N_ROWS;
    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [N-1:0][15:0] op;
        logic [N-1:0]       strb;
    } stim_t;

    typedef struct packed {
        logic [7:0]         tag;
        logic [N-1:0]       strb;
        logic [N-1:0][15:0] res;
        logic [31:0]        acc;
    } item_t;

    // Lane 0 is the rightmost operand.
    localparam stim_t TABLE [5] = '{
        '{op: {16'h3e80, 16'hbf00, 16'h3f00, 16'h0000}, strb: 4'hf},
        '{op: {16'hc120, 16'h4120, 16'hbf80, 16'h3f80}, strb: 4'hf},
        '{op: {16'hc2b0, 16'h42ae, 16'h42b2, 16'h42b1}, strb: 4'hf},
        '{op: {16'h0001, 16'hff80, 16'h7f80, 16'h7fc1}, strb: 4'hf},
        '{op: {16'h3c00, 16'h8001, 16'hc348, 16'h4348}, strb: 4'b1011}
    };

    logic clk_i = 1'b0;
    logic rst_ni, clear_i, enable_i, valid_i, ready_i;
    logic [N-1:0] strb_i;
    bf16_t [N-1:0] op_i;
    expu_tag_t tag_i;
    logic valid_o, ready_o, busy_o;
    logic [N-1:0] strb_o;
    expu_tag_t tag_o;
    bf16_t [N-1:0] res_o;

    item_t sb[$];
    int errors = 0;
    int tests = 0;
    int cycle = 0;
    logic check_lat = 1'b0;
    logic rand_ready = 1'b0;
    logic [31:0] op_lfsr = 32'd99704;
    logic [31:0] rdy_lfsr = 32'd99704;
    logic [7:0] next_tag = 8'h00;

    expu_top i_dut (.*);

    always #4 clk_i = ~clk_i;

    // Fibonacci LFSR with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Reference e^x from the arithmetic rule.
    function automatic logic [15:0] exp_model(input logic [15:0] op);
        int ex, m, sh, mag, x, t, i, e;
        ex = int'(op[14:7]);
        m = int'(op[6:0]);
        if (ex == 255) begin
            return (m != 0) ? 16'h7fc0 : (op[15] ? 16'h0000 : 16'h7f80);
        end
        if (ex >= 134) begin
            return op[15] ? 16'h0000 : 16'h7f80;
        end
        x = 0;
        if (ex != 0) begin
            sh = ex - 126;
            if (sh >= 0) mag = (128 + m) << sh;
            else if (-sh > 30) mag = 0;
            else mag = (128 + m) >> (-sh);
            x = op[15] ? -mag : mag;
        end
        t = (x * 1477) >>> 10;
        i = t >>> 8;
        e = i + 127;
        if (e <= 0) return 16'h0000;
        if (e >= 255) return 16'h7f80;
        return {1'b0, e[7:0], t[7:1]};
    endfunction

    task automatic give_up(input string what);
        $display("Timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // Called 1 ns after a rising edge; returns 1 ns after the accepting edge.
    task automatic send(input logic [N-1:0][15:0] ops, input logic [N-1:0] strb);
        item_t it;
        int waits;
        waits = 0;
        valid_i = 1'b1;
        op_i = ops;
        strb_i = strb;
        tag_i = next_tag;
        forever begin
            @(negedge clk_i);
            if (ready_o) break;
            waits++;
            if (waits > TIMEOUT) give_up("ready_o");
            @(posedge clk_i);
            #1;
        end
        assert (!check_lat || waits == 0) else begin
            $display("[ERROR] %0t: ready_o low with ready_i high", $time);
            errors++;
        end
        it.tag = next_tag;
        it.strb = strb;
        it.acc = cycle;
        for (int r = 0; r < N; r++) it.res[r] = exp_model(ops[r]);
        sb.push_back(it);
        next_tag++;
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic drain();
        int waits;
        waits = 0;
        while (sb.size() != 0 || busy_o) begin
            @(posedge clk_i);
            #1;
            waits++;
            if (waits > TIMEOUT) give_up("pipeline to drain");
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == start_errors) ? "ok" : "errors");
    endtask

    // Pairs each output transfer with the oldest sent item.
    always @(posedge clk_i) begin
        item_t e;
        cycle <= cycle + 1;
        if (rst_ni && valid_o && ready_i && enable_i && !clear_i) begin
            assert (sb.size() != 0) else begin
                $display("[ERROR] %0t: unexpected output with tag %0h", $time, tag_o);
                errors++;
            end
            if (sb.size() != 0) begin
                e = sb.pop_front();
                assert (tag_o == e.tag && strb_o == e.strb) else begin
                    $display("[ERROR] %0t: tag %0h strb %b, expected tag %0h strb %b",
                             $time, tag_o, strb_o, e.tag, e.strb);
                    errors++;
                end
                for (int r = 0; r < N; r++) begin
                    assert (!e.strb[r] || res_o[r] == e.res[r]) else begin
                        $display("[ERROR] %0t: tag %0h lane %0d got %h expected %h",
                                 $time, e.tag, r, res_o[r], e.res[r]);
                        errors++;
                    end
                end
                assert (!check_lat || cycle - int'(e.acc) == 3) else begin
                    $display("[ERROR] %0t: tag %0h latency %0d", $time, e.tag,
                             cycle - int'(e.acc));
                    errors++;
                end
            end
        end
    end

    // Random back-pressure, enabled at the edge and driven just after it.
    always @(posedge clk_i) begin
        logic stall_on;
        stall_on = rand_ready;
        #1;
        if (stall_on) begin
            rdy_lfsr = lfsr_step(rdy_lfsr);
            ready_i = rdy_lfsr[0];
        end
    end

    initial begin
        int start;
        int waits;
        logic [N-1:0][15:0] ops;
        logic [N-1:0] strb;
        expu_tag_t held_tag;
        rst_ni = 1'b0;
        clear_i = 1'b0;
        enable_i = 1'b1;
        valid_i = 1'b0;
        ready_i = 1'b1;
        strb_i = '0;
        op_i = '0;
        tag_i = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        start = errors;
        for (int k = 0; k < 3; k++) send(TABLE[k].op, TABLE[k].strb);
        drain();
        end_test("table values", start);

        start = errors;
        for (int k = 3; k < 5; k++) send(TABLE[k].op, TABLE[k].strb);
        drain();
        end_test("special inputs", start);

        start = errors;
        check_lat = 1'b1;
        for (int k = 0; k < 5; k++) send(TABLE[k].op, TABLE[k].strb);
        drain();
        check_lat = 1'b0;
        end_test("latency and throughput", start);

        start = errors;
        rand_ready = 1'b1;
        for (int k = 0; k < 24; k++) begin
            for (int r = 0; r < N; r++) begin
                ops[r] = '0;
                for (int b = 0; b < 12; b++) begin
                    op_lfsr = lfsr_step(op_lfsr);
                    ops[r][b] = op_lfsr[0];
                end
                // Keep exponents near the useful range.
                ops[r][15] = ops[r][11];
                ops[r][14:11] = 4'b0111;
            end
            for (int b = 0; b < N; b++) begin
                op_lfsr = lfsr_step(op_lfsr);
                strb[b] = op_lfsr[0];
            end
            send(ops, strb);
        end
        rand_ready = 1'b0;
        @(posedge clk_i);
        #1;
        ready_i = 1'b1;
        drain();
        end_test("random stalls", start);

        start = errors;
        ready_i = 1'b0;
        send(TABLE[0].op, TABLE[0].strb);
        send(TABLE[1].op, TABLE[1].strb);
        waits = 0;
        while (!valid_o) begin
            @(posedge clk_i);
            #1;
            waits++;
            if (waits > TIMEOUT) give_up("valid_o before freeze");
        end
        enable_i = 1'b0;
        ready_i = 1'b1;
        held_tag = tag_o;
        repeat (4) begin
            @(negedge clk_i);
            assert (!ready_o && valid_o && busy_o && tag_o == held_tag) else begin
                $display("[ERROR] %0t: pipeline moved while disabled", $time);
                errors++;
            end
        end
        @(posedge clk_i);
        #1;
        enable_i = 1'b1;
        drain();
        send(TABLE[2].op, TABLE[2].strb);
        send(TABLE[3].op, TABLE[3].strb);
        clear_i = 1'b1;
        @(posedge clk_i);
        #1;
        clear_i = 1'b0;
        sb.delete();
        assert (!busy_o && !valid_o) else begin
            $display("[ERROR] %0t: busy_o %b valid_o %b after clear", $time, busy_o, valid_o);
            errors++;
        end
        repeat (6) @(posedge clk_i);
        #1;
        end_test("enable, clear and busy", start);

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
expu_pkg.sv
expu_decode.sv
expu_execute.sv
expu_result.sv
expu_row.sv
expu_pipe_ctrl.sv
expu_top.sv
expu_sva.sv
tb_expu_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the expu testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f vlog.f --top-module tb_expu_top -o sim_expu
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_expu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
